// File: hw/box_pkg.sv
package box_pkg;

  // frame geometry.
  localparam int frame_rows = 6;
  localparam int frame_cols = 16;
  localparam int frame_pix  = frame_rows * frame_cols;
  localparam int win_len    = 5;
  localparam int win_count  = frame_cols - win_len + 1;

  // datapath widths.
  localparam int pix_w     = 8;
  localparam int sum_w     = 16;  // 255 * 30 fits.
  localparam int col_w     = 4;
  localparam int row_w     = 3;
  localparam int fr_addr_w = row_w + col_w;

  localparam int wb_adr_w = 12;
  localparam int wb_dat_w = 32;

  // column and row markers used by the controller and the summer.
  localparam logic [col_w-1:0] fill_exit_col = col_w'(win_len - 2);
  localparam logic [col_w-1:0] win_first_col = col_w'(win_len - 1);
  localparam logic [col_w-1:0] last_col      = col_w'(frame_cols - 1);
  localparam logic [row_w-1:0] last_row_idx  = row_w'(frame_rows - 1);

  // wishbone byte address map, one 32-bit word per entry.
  localparam logic [wb_adr_w-1:0] frame_base  = 12'h000;
  localparam logic [wb_adr_w-1:0] ctrl_addr   = 12'h200;
  localparam logic [wb_adr_w-1:0] status_addr = 12'h204;
  localparam logic [wb_adr_w-1:0] result_base = 12'h300;
  localparam logic [wb_adr_w-1:0] frame_span  = wb_adr_w'(4 * frame_pix);
  localparam logic [wb_adr_w-1:0] result_span = wb_adr_w'(4 * win_count);

  typedef enum logic [2:0] {
    st_idle,
    st_clear,
    st_start_row,
    st_fill,
    st_accum,
    st_finish
  } ctrl_state_e;

endpackage

// File: hw/pixel_stream_if.sv
`timescale 1ns/1ps

interface pixel_stream_if;

  logic [box_pkg::pix_w-1:0] pix;
  logic [box_pkg::col_w-1:0] pix_col;
  logic                      pix_valid;  // one beat per pixel, no stall.
  logic                      row_first;  // pixel belongs to row 0.

  modport src (
    output pix,
    output pix_col,
    output pix_valid,
    output row_first
  );

  modport dst (
    input pix,
    input pix_col,
    input pix_valid,
    input row_first
  );

endinterface

// File: hw/box_ctrl.sv
`timescale 1ns/1ps

module box_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic [box_pkg::col_w-1:0] col_count,
  input  logic                      last_row,
  output logic                      row_load,
  output logic                      col_en,
  output logic                      row_next,
  output logic                      clear,
  output logic                      acc_clear,
  output logic                      busy,
  output logic                      done_pulse
);

  box_pkg::ctrl_state_e state;
  box_pkg::ctrl_state_e state_nxt;
  logic                 row_end;

  assign row_end = (col_count == box_pkg::last_col);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= box_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      box_pkg::st_idle: begin
        state_nxt = start ? box_pkg::st_clear : box_pkg::st_idle;
      end
      box_pkg::st_clear: begin
        state_nxt = box_pkg::st_start_row;
      end
      box_pkg::st_start_row: begin
        state_nxt = box_pkg::st_fill;
      end
      box_pkg::st_fill: begin
        // counter reaches win_len-1 on this edge.
        if (col_count == box_pkg::fill_exit_col) begin
          state_nxt = box_pkg::st_accum;
        end
      end
      box_pkg::st_accum: begin
        if (row_end) begin
          state_nxt = last_row ? box_pkg::st_finish : box_pkg::st_start_row;
        end
      end
      box_pkg::st_finish: begin
        state_nxt = box_pkg::st_idle;
      end
      default: begin
        state_nxt = box_pkg::st_idle;
      end
    endcase
  end

  always_comb begin
    row_load   = 1'b0;
    col_en     = 1'b0;
    row_next   = 1'b0;
    clear      = 1'b0;
    acc_clear  = 1'b0;
    done_pulse = 1'b0;
    case (state)
      box_pkg::st_clear: begin
        clear     = 1'b1;
        acc_clear = 1'b1;
      end
      box_pkg::st_start_row: begin
        row_load = 1'b1;
      end
      box_pkg::st_fill: begin
        col_en = 1'b1;
      end
      box_pkg::st_accum: begin
        col_en   = 1'b1;
        row_next = row_end && !last_row;  // row counter stops on the last row.
      end
      box_pkg::st_finish: begin
        done_pulse = 1'b1;  // the last sum lands in the accumulator two cycles later.
      end
      default: begin
      end
    endcase
  end

  assign busy = (state != box_pkg::st_idle);

  a_no_col_en_idle: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {box_pkg::st_idle, box_pkg::st_finish} |-> !col_en);

  a_acc_clear_only_clear: assert property (@(posedge clk) disable iff (!rst_n)
    acc_clear |-> state == box_pkg::st_clear);

endmodule

// File: hw/pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fr_we,
  input  logic [box_pkg::fr_addr_w-1:0] fr_addr,
  input  logic [box_pkg::pix_w-1:0]     fr_data,
  input  logic                          row_load,
  input  logic                          col_en,
  input  logic                          row_next,
  input  logic                          clear,
  output logic [box_pkg::col_w-1:0]     col_count,
  output logic                          last_row,
  pixel_stream_if.src                   stream
);

  logic [box_pkg::pix_w-1:0]     frame_mem [box_pkg::frame_pix];
  logic [box_pkg::row_w-1:0]     row_count;
  logic [box_pkg::fr_addr_w-1:0] rd_addr;

  assign rd_addr  = {row_count, col_count};  // row-major, 16 columns per row.
  assign last_row = (row_count == box_pkg::last_row_idx);

  always_ff @(posedge clk) begin
    if (fr_we) begin
      frame_mem[fr_addr] <= fr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_count <= '0;
    end else if (clear) begin
      row_count <= '0;
    end else if (row_next) begin
      row_count <= row_count + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_count <= '0;
    end else if (row_load) begin
      col_count <= '0;
    end else if (col_en) begin
      col_count <= col_count + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stream.pix_valid <= 1'b0;
    end else begin
      stream.pix_valid <= col_en;  // pixel shows up one cycle after col_en.
    end
  end

  always_ff @(posedge clk) begin
    if (col_en) begin
      stream.pix       <= frame_mem[rd_addr];
      stream.pix_col   <= col_count;
      stream.row_first <= (row_count == '0);
    end
  end

endmodule

// File: hw/window_sum.sv
`timescale 1ns/1ps

module window_sum (
  input  logic                      clk,
  input  logic                      rst_n,
  pixel_stream_if.dst               stream,
  output logic [box_pkg::sum_w-1:0] hsum,
  output logic [box_pkg::col_w-1:0] hsum_idx,
  output logic                      hsum_valid,
  output logic                      hsum_first
);

  logic [box_pkg::pix_w-1:0] taps [box_pkg::win_len];
  logic [box_pkg::sum_w-1:0] run_sum;
  logic [box_pkg::sum_w-1:0] sum_nxt;
  logic [2:0]                fill_cnt;
  logic                      win_full;

  // add the new pixel, drop the one that leaves the window.
  assign sum_nxt = run_sum
                 + {{(box_pkg::sum_w - box_pkg::pix_w){1'b0}}, stream.pix}
                 - {{(box_pkg::sum_w - box_pkg::pix_w){1'b0}}, taps[box_pkg::win_len-1]};
  assign win_full = (stream.pix_col >= box_pkg::win_first_col);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < box_pkg::win_len; i++) begin
        taps[i] <= '0;
      end
      run_sum  <= '0;
      fill_cnt <= '0;
    end else if (stream.pix_valid) begin
      taps[0] <= stream.pix;
      for (int i = 1; i < box_pkg::win_len; i++) begin
        taps[i] <= taps[i-1];
      end
      run_sum <= sum_nxt;
      if (stream.pix_col == '0) begin
        fill_cnt <= 3'd1;  // new row starts.
      end else if (fill_cnt != 3'(box_pkg::win_len)) begin
        fill_cnt <= fill_cnt + 3'd1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hsum_valid <= 1'b0;
    end else begin
      hsum_valid <= stream.pix_valid && win_full;
    end
  end

  always_ff @(posedge clk) begin
    if (stream.pix_valid && win_full) begin
      hsum       <= sum_nxt;
      hsum_idx   <= stream.pix_col - box_pkg::win_first_col;
      hsum_first <= stream.row_first;
    end
  end

  // every emitted sum covers five pixels of the current row.
  a_window_filled: assert property (@(posedge clk) disable iff (!rst_n)
    hsum_valid |-> fill_cnt == 3'(box_pkg::win_len));

endmodule

// File: hw/column_accum.sv
`timescale 1ns/1ps

module column_accum (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      acc_clear,
  input  logic [box_pkg::sum_w-1:0] hsum,
  input  logic [box_pkg::col_w-1:0] hsum_idx,
  input  logic                      hsum_valid,
  input  logic                      hsum_first,
  input  logic [box_pkg::col_w-1:0] res_addr,
  output logic [box_pkg::sum_w-1:0] res_data
);

  logic [box_pkg::sum_w-1:0] acc [box_pkg::win_count];
  logic                      res_in_range;

  // results read as zero until the first run completes.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < box_pkg::win_count; i++) begin
        acc[i] <= '0;
      end
    end else if (acc_clear) begin
      for (int i = 0; i < box_pkg::win_count; i++) begin
        acc[i] <= '0;
      end
    end else if (hsum_valid) begin
      if (hsum_first) begin
        acc[hsum_idx] <= hsum;  // row 0 overwrites.
      end else begin
        acc[hsum_idx] <= acc[hsum_idx] + hsum;
      end
    end
  end

  assign res_in_range = (res_addr < box_pkg::col_w'(box_pkg::win_count));

  always_comb begin
    res_data = '0;
    if (res_in_range) begin
      res_data = acc[res_addr];
    end
  end

endmodule

// File: hw/wb_regs.sv
`timescale 1ns/1ps

module wb_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [box_pkg::wb_adr_w-1:0]  wb_adr,
  input  logic [box_pkg::wb_dat_w-1:0]  wb_dat_i,
  output logic [box_pkg::wb_dat_w-1:0]  wb_dat_o,
  output logic                          wb_ack,
  output logic                          fr_we,
  output logic [box_pkg::fr_addr_w-1:0] fr_addr,
  output logic [box_pkg::pix_w-1:0]     fr_data,
  output logic                          start,
  input  logic                          busy,
  input  logic                          done_pulse,
  output logic [box_pkg::col_w-1:0]     res_addr,
  input  logic [box_pkg::sum_w-1:0]     res_data
);

  logic                         req;
  logic [box_pkg::wb_adr_w-1:0] frame_off;
  logic [box_pkg::wb_adr_w-1:0] result_off;
  logic                         frame_hit;
  logic                         ctrl_hit;
  logic                         status_hit;
  logic                         result_hit;
  logic                         done;
  logic [box_pkg::wb_dat_w-1:0] rd_data;

  assign req = wb_cyc && wb_stb && !wb_ack;  // one ack per request.

  // offsets wrap below the base, so one compare covers both ends.
  assign frame_off  = wb_adr - box_pkg::frame_base;
  assign result_off = wb_adr - box_pkg::result_base;
  assign frame_hit  = (frame_off < box_pkg::frame_span);
  assign result_hit = (result_off < box_pkg::result_span);
  assign ctrl_hit   = (wb_adr == box_pkg::ctrl_addr);
  assign status_hit = (wb_adr == box_pkg::status_addr);

  assign fr_we    = req && wb_we && frame_hit;
  assign fr_addr  = frame_off[box_pkg::fr_addr_w+1:2];
  assign fr_data  = wb_dat_i[box_pkg::pix_w-1:0];
  assign res_addr = result_off[box_pkg::col_w+1:2];
  assign start    = req && wb_we && ctrl_hit && wb_dat_i[0] && !busy;

  always_comb begin
    rd_data = '0;
    if (status_hit) begin
      rd_data[1:0] = {done, busy};
    end else if (result_hit) begin
      rd_data[box_pkg::sum_w-1:0] = res_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      done   <= 1'b0;
    end else begin
      wb_ack <= req;
      if (start) begin
        done <= 1'b0;
      end else if (done_pulse) begin
        done <= 1'b1;  // sticky until the next run.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req && !wb_we) begin
      wb_dat_o <= rd_data;
    end
  end

  a_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

// File: hw/box_sum_top.sv
`timescale 1ns/1ps

module box_sum_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [11:0] wb_adr,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack
);

  logic                          fr_we;
  logic [box_pkg::fr_addr_w-1:0] fr_addr;
  logic [box_pkg::pix_w-1:0]     fr_data;
  logic                          start;
  logic                          busy;
  logic                          done_pulse;
  logic [box_pkg::col_w-1:0]     res_addr;
  logic [box_pkg::sum_w-1:0]     res_data;
  logic                          row_load;
  logic                          col_en;
  logic                          row_next;
  logic                          clear;
  logic                          acc_clear;
  logic [box_pkg::col_w-1:0]     col_count;
  logic                          last_row;
  logic [box_pkg::sum_w-1:0]     hsum;
  logic [box_pkg::col_w-1:0]     hsum_idx;
  logic                          hsum_valid;
  logic                          hsum_first;

  pixel_stream_if pix_stream ();

  wb_regs i_wb_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack     (wb_ack),
    .fr_we      (fr_we),
    .fr_addr    (fr_addr),
    .fr_data    (fr_data),
    .start      (start),
    .busy       (busy),
    .done_pulse (done_pulse),
    .res_addr   (res_addr),
    .res_data   (res_data)
  );

  box_ctrl i_box_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .col_count  (col_count),
    .last_row   (last_row),
    .row_load   (row_load),
    .col_en     (col_en),
    .row_next   (row_next),
    .clear      (clear),
    .acc_clear  (acc_clear),
    .busy       (busy),
    .done_pulse (done_pulse)
  );

  pixel_fetch i_pixel_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .fr_we     (fr_we),
    .fr_addr   (fr_addr),
    .fr_data   (fr_data),
    .row_load  (row_load),
    .col_en    (col_en),
    .row_next  (row_next),
    .clear     (clear),
    .col_count (col_count),
    .last_row  (last_row),
    .stream    (pix_stream.src)
  );

  window_sum i_window_sum (
    .clk        (clk),
    .rst_n      (rst_n),
    .stream     (pix_stream.dst),
    .hsum       (hsum),
    .hsum_idx   (hsum_idx),
    .hsum_valid (hsum_valid),
    .hsum_first (hsum_first)
  );

  column_accum i_column_accum (
    .clk        (clk),
    .rst_n      (rst_n),
    .acc_clear  (acc_clear),
    .hsum       (hsum),
    .hsum_idx   (hsum_idx),
    .hsum_valid (hsum_valid),
    .hsum_first (hsum_first),
    .res_addr   (res_addr),
    .res_data   (res_data)
  );

endmodule

// File: sim/box_sum_tb.sv
`timescale 1ns/1ps

module box_sum_tb;

  localparam int clk_period    = 20;
  localparam int reset_cycles  = 16;
  localparam int num_tests     = 5;
  localparam int poll_limit    = 200;
  localparam int access_cycles = 3;  // worst case for one wishbone access.
  localparam int test_accesses = box_pkg::frame_pix + poll_limit + box_pkg::win_count + 16;
  localparam int watchdog_cycles = reset_cycles + 2 * num_tests * test_accesses * access_cycles;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [11:0] wb_adr;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack;

  logic [box_pkg::pix_w-1:0] frame [box_pkg::frame_pix];  // copy of the loaded frame.
  logic [31:0]               rng_state;

  box_sum_top i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else
      fail_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  task automatic wb_write(input logic [11:0] adr, input logic [31:0] data);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_i = data;
    @(negedge clk);
    while (wb_ack !== 1'b1) @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [11:0] adr, output logic [31:0] data);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    while (wb_ack !== 1'b1) @(negedge clk);
    data   = wb_dat_o;  // registered on the ack edge.
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // box sum j covers columns j to j+4 over every row.
  function automatic logic [31:0] expected_sum(input int j);
    int sum;
    sum = 0;
    for (int r = 0; r < box_pkg::frame_rows; r++) begin
      for (int k = 0; k < box_pkg::win_len; k++) begin
        sum += frame[r * box_pkg::frame_cols + j + k];
      end
    end
    return 32'(sum);
  endfunction

  task automatic load_frame();
    for (int i = 0; i < box_pkg::frame_pix; i++) begin
      wb_write(box_pkg::frame_base + 12'(4 * i), {24'h0, frame[i]});
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < box_pkg::frame_pix; i++) begin
      rng_state = xorshift32(rng_state);
      frame[i]  = rng_state[7:0];
    end
  endtask

  task automatic start_run();
    wb_write(box_pkg::ctrl_addr, 32'h1);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    int          polls;
    polls = 0;
    do begin
      wb_read(box_pkg::status_addr, st);
      polls++;
    end while (!st[1] && polls < poll_limit);
    assert (st[1]) else fail_run("done bit never set in the status register");
    check_equal("status", st, 32'h2);
  endtask

  task automatic check_results();
    logic [31:0] d;
    for (int j = 0; j < box_pkg::win_count; j++) begin
      wb_read(box_pkg::result_base + 12'(4 * j), d);
      check_equal($sformatf("result[%0d]", j), d, expected_sum(j));
    end
  endtask

  task automatic test_reset_values();
    logic [31:0] d;
    wb_read(box_pkg::status_addr, d);
    check_equal("status", d, 32'h0);
    for (int j = 0; j < box_pkg::win_count; j++) begin
      wb_read(box_pkg::result_base + 12'(4 * j), d);
      check_equal($sformatf("result[%0d]", j), d, 32'h0);
    end
  endtask

  task automatic test_ramp_frame();
    for (int r = 0; r < box_pkg::frame_rows; r++) begin
      for (int c = 0; c < box_pkg::frame_cols; c++) begin
        frame[r * box_pkg::frame_cols + c] = 8'(r + c);
      end
    end
    load_frame();
    start_run();
    wait_done();
    check_results();
  endtask

  task automatic test_random_frame();
    fill_random();
    // one window at full scale, the largest possible sum.
    for (int r = 0; r < box_pkg::frame_rows; r++) begin
      for (int c = 11; c < box_pkg::frame_cols; c++) begin
        frame[r * box_pkg::frame_cols + c] = 8'hff;
      end
    end
    load_frame();
    start_run();
    wait_done();
    check_results();
  endtask

  task automatic test_restart();
    logic [31:0] d;
    wb_read(box_pkg::status_addr, d);
    check_equal("status", d, 32'h2);
    fill_random();
    load_frame();
    start_run();
    wb_read(box_pkg::status_addr, d);
    check_equal("status", d, 32'h1);  // busy, done cleared by the start.
    wait_done();
    check_results();
  endtask

  task automatic test_busy_start();
    logic [31:0] d;
    start_run();
    start_run();  // lands while busy.
    wb_read(box_pkg::status_addr, d);
    check_equal("status", d, 32'h1);
    wait_done();
    check_results();
    wb_read(12'h180, d);
    check_equal("unmapped 0x180", d, 32'h0);
    wb_read(12'h208, d);
    check_equal("unmapped 0x208", d, 32'h0);
    wb_read(12'h330, d);
    check_equal("unmapped 0x330", d, 32'h0);
    wb_read(12'hffc, d);
    check_equal("unmapped 0xffc", d, 32'h0);
    wb_write(12'h208, 32'h1);
    wb_read(box_pkg::status_addr, d);
    check_equal("status", d, 32'h2);
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    fail_run("timeout: the tests did not finish in the expected time");
  end

  initial begin
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_i  = '0;
    rng_state = 32'hf8a2_cc05;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;

    test_reset_values();
    test_ramp_frame();
    test_random_frame();
    test_restart();
    test_busy_start();

    $display("sim passed");
    $finish;
  end

endmodule

// File: box_sum.f
hw/box_pkg.sv
hw/pixel_stream_if.sv
hw/box_ctrl.sv
hw/pixel_fetch.sv
hw/window_sum.sv
hw/column_accum.sv
hw/wb_regs.sv
hw/box_sum_top.sv
sim/box_sum_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f box_sum.f --top-module box_sum_tb -o box_sum_sim

./obj_dir/box_sum_sim 2>&1 | tee sim.log || true

if grep -q "^sim passed$" sim.log; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi
